// File: hw/compressed_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module compressed_decoder import isa_pkg::*, fetch_pkg::*; (
  input  wire aligned_t aligned_i,
  output if_id_t        if_id_o
);

  logic [15:0] c;

  assign c = aligned_i.instr[15:0];

  ////////////////////////////////////////////////////////////////////////////
  // RVC expansion, illegal entries keep the raw word
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if_id_o.instr         = aligned_i.instr;
    if_id_o.pc            = aligned_i.pc;
    if_id_o.is_compressed = aligned_i.is_compressed;
    if_id_o.bus_err       = aligned_i.bus_err;
    if_id_o.illegal       = 1'b0;

    if (aligned_i.is_compressed) begin
      unique case (c[1:0])
        // quadrant 0
        2'b00: begin
          unique case (c[15:13])
            3'b000: begin
              // c.addi4spn, zero immediate is reserved
              if (c[12:5] == 8'h00) begin
                if_id_o.illegal = 1'b1;
              end else begin
                if_id_o.instr = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                                 REG_SP, F3_ADD, 2'b01, c[4:2], OPCODE_OPIMM};
              end
            end
            3'b010: begin
              // c.lw
              if_id_o.instr = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7],
                               F3_W, 2'b01, c[4:2], OPCODE_LOAD};
            end
            3'b110: begin
              // c.sw
              if_id_o.instr = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7],
                               F3_W, c[11:10], c[6], 2'b00, OPCODE_STORE};
            end
            // fp loads and stores, plus the reserved slot
            default: if_id_o.illegal = 1'b1;
          endcase
        end

        // quadrant 1
        2'b01: begin
          unique case (c[15:13])
            3'b000: begin
              // c.addi and c.nop
              if_id_o.instr = {{6{c[12]}}, c[12], c[6:2], c[11:7], F3_ADD, c[11:7],
                               OPCODE_OPIMM};
            end
            3'b001, 3'b101: begin
              // c.jal links x1, c.j links x0
              if_id_o.instr = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                               {9{c[12]}}, 4'b0000, ~c[15], OPCODE_JAL};
            end
            3'b010: begin
              // c.li, rd x0 is a hint and expands the same way
              if_id_o.instr = {{6{c[12]}}, c[12], c[6:2], REG_ZERO, F3_ADD, c[11:7],
                               OPCODE_OPIMM};
            end
            3'b011: begin
              if ({c[12], c[6:2]} == 6'b0) begin
                if_id_o.illegal = 1'b1;
              end else if (c[11:7] == REG_SP) begin
                // c.addi16sp
                if_id_o.instr = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                                 REG_SP, F3_ADD, REG_SP, OPCODE_OPIMM};
              end else begin
                // c.lui
                if_id_o.instr = {{15{c[12]}}, c[6:2], c[11:7], OPCODE_LUI};
              end
            end
            3'b100: begin
              unique case (c[11:10])
                2'b00, 2'b01: begin
                  // c.srli / c.srai, shamt[5] set is reserved on rv32
                  if (c[12]) begin
                    if_id_o.illegal = 1'b1;
                  end else begin
                    if_id_o.instr = {1'b0, c[10], 5'b0, c[6:2], 2'b01, c[9:7], F3_SR,
                                     2'b01, c[9:7], OPCODE_OPIMM};
                  end
                end
                2'b10: begin
                  // c.andi
                  if_id_o.instr = {{6{c[12]}}, c[12], c[6:2], 2'b01, c[9:7], F3_AND,
                                   2'b01, c[9:7], OPCODE_OPIMM};
                end
                default: begin
                  if (c[12]) begin
                    // c.subw, c.addw and reserved
                    if_id_o.illegal = 1'b1;
                  end else begin
                    unique case (c[6:5])
                      2'b00: if_id_o.instr = {7'b0100000, 2'b01, c[4:2], 2'b01, c[9:7],
                                              F3_ADD, 2'b01, c[9:7], OPCODE_OP};
                      2'b01: if_id_o.instr = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7],
                                              F3_XOR, 2'b01, c[9:7], OPCODE_OP};
                      2'b10: if_id_o.instr = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7],
                                              F3_OR, 2'b01, c[9:7], OPCODE_OP};
                      default: if_id_o.instr = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7],
                                                F3_AND, 2'b01, c[9:7], OPCODE_OP};
                    endcase
                  end
                end
              endcase
            end
            default: begin
              // c.beqz / c.bnez, c[13] picks the funct3
              if_id_o.instr = {{4{c[12]}}, c[6:5], c[2], REG_ZERO, 2'b01, c[9:7],
                               2'b00, c[13], c[11:10], c[4:3], c[12], OPCODE_BRANCH};
            end
          endcase
        end

        // quadrant 2
        2'b10: begin
          unique case (c[15:13])
            3'b000: begin
              // c.slli, hints with rd x0 or shamt 0 pass as slli
              if (c[12]) begin
                if_id_o.illegal = 1'b1;
              end else begin
                if_id_o.instr = {7'b0, c[6:2], c[11:7], F3_SLL, c[11:7], OPCODE_OPIMM};
              end
            end
            3'b010: begin
              // c.lwsp, rd x0 reserved
              if (c[11:7] == REG_ZERO) begin
                if_id_o.illegal = 1'b1;
              end else begin
                if_id_o.instr = {4'b0, c[3:2], c[12], c[6:4], 2'b00, REG_SP, F3_W,
                                 c[11:7], OPCODE_LOAD};
              end
            end
            3'b100: begin
              if (c[6:2] != 5'b0) begin
                // c.mv adds to x0, c.add adds to rd
                if_id_o.instr = {7'b0, c[6:2], c[12] ? c[11:7] : REG_ZERO, F3_ADD,
                                 c[11:7], OPCODE_OP};
              end else if (c[11:7] == REG_ZERO) begin
                // c.ebreak, or the reserved c.jr x0
                if (c[12]) begin
                  if_id_o.instr = EBREAK_INSTR;
                end else begin
                  if_id_o.illegal = 1'b1;
                end
              end else begin
                // c.jr / c.jalr
                if_id_o.instr = {12'h000, c[11:7], 3'b000, c[12] ? REG_RA : REG_ZERO,
                                 OPCODE_JALR};
              end
            end
            3'b110: begin
              // c.swsp
              if_id_o.instr = {4'b0, c[8:7], c[12], c[6:2], REG_SP, F3_W, c[11:9],
                               2'b00, OPCODE_STORE};
            end
            // fp stack loads and stores
            default: if_id_o.illegal = 1'b1;
          endcase
        end

        // not compressed, aligner never flags these
        default: if_id_o.instr = aligned_i.instr;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// response words held in the prefetch FIFO
`define FIFO_DEPTH 4

// first fetch address out of reset
`define BOOT_ADDR 32'h0000_0080

`endif

// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // one memory response word
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_resp_t;

  // instruction as cut out of the word stream
  // upper half is zero for compressed entries
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        is_compressed;
    logic        bus_err;
  } aligned_t;

  // payload handed to decode
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        is_compressed;
    logic        illegal;
    logic        bus_err;
  } if_id_t;

endpackage

`default_nettype wire

// File: hw/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage import fetch_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        resp_valid_i,
  input  wire bus_resp_t   resp_i,
  input  wire logic        jump_i,
  input  wire logic [31:0] jump_addr_i,
  input  wire logic        id_ready_i,
  output logic             space_o,
  output logic             instr_valid_o,
  output if_id_t           if_id_o
);

  logic      head_valid;
  bus_resp_t head;
  logic      pop;
  aligned_t  aligned;

  ////////////////////////////////////////////////////////////////////////////
  // response words, flushed on jump
  ////////////////////////////////////////////////////////////////////////////

  prefetch_fifo u_prefetch_fifo (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (jump_i),
    .wr_i         (resp_valid_i),
    .wr_data_i    (resp_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_o       (head),
    .space_o      (space_o)
  );

  // cuts words into 16/32-bit instrs and owns the output register
  instr_aligner u_instr_aligner (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .jump_i       (jump_i),
    .jump_addr_i  (jump_addr_i),
    .head_valid_i (head_valid),
    .head_i       (head),
    .ready_i      (id_ready_i),
    .pop_o        (pop),
    .out_valid_o  (instr_valid_o),
    .aligned_o    (aligned)
  );

  // expansion after the register, same cycle to decode
  compressed_decoder u_compressed_decoder (
    .aligned_i (aligned),
    .if_id_o   (if_id_o)
  );

endmodule

`default_nettype wire

// File: hw/instr_aligner.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module instr_aligner import fetch_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        jump_i,
  input  wire logic [31:0] jump_addr_i,
  input  wire logic        head_valid_i,
  input  wire bus_resp_t   head_i,
  input  wire logic        ready_i,
  output logic             pop_o,
  output logic             out_valid_o,
  output aligned_t         aligned_o
);

  logic [31:0] pc_q;
  logic        half_q;       // next instr starts in the upper half of the head
  logic        held_valid_q; // lower half of a straddling instr is parked
  logic [15:0] held_q;
  logic        held_err_q;
  logic        out_valid_q;
  aligned_t    out_q;

  logic [15:0] head_hw;
  logic        hw_is_comp;
  logic        avail;
  logic        stash;
  logic        load_en;
  logic        load;
  aligned_t    next_out;

  ////////////////////////////////////////////////////////////////////////////
  // length decode on the next half-word
  ////////////////////////////////////////////////////////////////////////////

  assign head_hw    = half_q ? head_i.rdata[31:16] : head_i.rdata[15:0];
  assign hw_is_comp = (head_hw[1:0] != 2'b11);

  // complete instr at hand: finishing a straddle, a compressed half, or a full word
  assign avail = head_valid_i && (held_valid_q || hw_is_comp || !half_q);
  // 32-bit instr begins in the upper half, park it and move on
  assign stash = head_valid_i && !held_valid_q && half_q && !hw_is_comp;

  // output register free or being drained this edge
  assign load_en = !out_valid_q || ready_i;
  assign load    = avail && load_en;

  // head word is done once its upper half has been used
  assign pop_o = !jump_i &&
                 (stash || (load && !held_valid_q && (half_q || !hw_is_comp)));

  always_comb begin
    next_out.pc = pc_q;
    if (held_valid_q) begin
      next_out.instr         = {head_i.rdata[15:0], held_q};
      next_out.is_compressed = 1'b0;
      next_out.bus_err       = held_err_q | head_i.err;
    end else if (hw_is_comp) begin
      next_out.instr         = {16'h0000, head_hw};
      next_out.is_compressed = 1'b1;
      next_out.bus_err       = head_i.err;
    end else begin
      // only reached with half_q low, so the whole word is the instr
      next_out.instr         = head_i.rdata;
      next_out.is_compressed = 1'b0;
      next_out.bus_err       = head_i.err;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q         <= `BOOT_ADDR;
      half_q       <= 1'b0;
      held_valid_q <= 1'b0;
      out_valid_q  <= 1'b0;
    end else if (jump_i) begin
      // restart, bit 1 of the target skips the low half of the first word
      pc_q         <= jump_addr_i;
      half_q       <= jump_addr_i[1];
      held_valid_q <= 1'b0;
      out_valid_q  <= 1'b0;
    end else begin
      if (stash) begin
        held_valid_q <= 1'b1;
        half_q       <= 1'b0;
      end
      if (load_en) begin
        out_valid_q <= avail;
      end
      if (load) begin
        pc_q <= pc_q + (next_out.is_compressed ? 32'd2 : 32'd4);
        if (held_valid_q) begin
          // straddle done, rest of this word starts at its upper half
          held_valid_q <= 1'b0;
          half_q       <= 1'b1;
        end else if (hw_is_comp) begin
          half_q <= !half_q;
        end
      end
    end
  end

  // payload, qualified by out_valid_q
  always_ff @(posedge clk_i) begin
    if (stash) begin
      held_q     <= head_hw;
      held_err_q <= head_i.err;
    end
    if (load) begin
      out_q <= next_out;
    end
  end

  assign out_valid_o = out_valid_q;
  assign aligned_o   = out_q;

endmodule

`default_nettype wire

// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // RV32 major opcodes produced by the RVC expansion
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OPIMM  = 7'h13,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f,
    OPCODE_SYSTEM = 7'h73
  } opcode_e;

  // fixed registers named by compressed forms
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  // funct3 values
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_W   = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SR  = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // ebreak, imm = 1 on the system opcode
  localparam logic [31:0] EBREAK_INSTR = {12'h001, 13'h0000, OPCODE_SYSTEM};

endpackage

`default_nettype wire

// File: hw/prefetch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module prefetch_fifo import fetch_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_i,
  input  wire logic      flush_i,
  input  wire logic      wr_i,
  input  wire bus_resp_t wr_data_i,
  input  wire logic      pop_i,
  output logic           head_valid_o,
  output bus_resp_t      head_o,
  output logic           space_o
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  bus_resp_t            mem_q [`FIFO_DEPTH];
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [CNT_W-1:0]     count_q;
  logic                 do_pop;

  // pops on an empty buffer are ignored
  assign do_pop = pop_i && head_valid_o;

  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];
  assign space_o      = (count_q < CNT_W'(`FIFO_DEPTH));

  // storage, a write during flush lands in slot 0 of the new stream
  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      mem_q[flush_i ? '0 : wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // drop everything, keep only a same-cycle write
      rd_ptr_q <= '0;
      wr_ptr_q <= wr_i ? PTR_W'(1) : '0;
      count_q  <= wr_i ? CNT_W'(1) : '0;
    end else begin
      if (wr_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // write plus pop leaves the count alone
      if (wr_i && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!wr_i && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/prefetch_fifo.sv
hw/instr_aligner.sv
hw/compressed_decoder.sv
hw/if_stage.sv
verif/tb_if_stage.sv

// File: run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
verilator --binary --timing -f list.f --top-module tb_if_stage -o sim_if_stage \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_if_stage > sim.log 2>&1 || { echo "simulation error, see sim.log"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

// File: verif/tb_if_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module tb_if_stage import isa_pkg::*, fetch_pkg::*; ();

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        resp_valid_i;
  bus_resp_t   resp_i;
  logic        jump_i;
  logic [31:0] jump_addr_i;
  logic        id_ready_i;
  logic        space_o;
  logic        instr_valid_o;
  if_id_t      if_id_o;

  integer      seed = 32'hb9a87e1b;
  int          err_cnt = 0;
  int          queued = 0;
  longint      limit_ns = 1000;
  logic [15:0] hw_q[$];     // program halfwords of the next stream
  if_id_t      exp_q[$];    // transfers still expected
  bit          stalled_q = 0;
  if_id_t      stall_val;
  bit          saw_full = 0;

  if_stage DUT (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .resp_valid_i  (resp_valid_i),
    .resp_i        (resp_i),
    .jump_i        (jump_i),
    .jump_addr_i   (jump_addr_i),
    .id_ready_i    (id_ready_i),
    .space_o       (space_o),
    .instr_valid_o (instr_valid_o),
    .if_id_o       (if_id_o)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // reference RVC expansion from immediates and RV32 formats
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] fmt_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] fmt_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic logic [31:0] fmt_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic logic [31:0] ref_expand(input logic [15:0] c, output logic ill);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rsp;
    logic [11:0] imm6;
    logic [11:0] off;
    logic [20:0] joff;
    logic [12:0] boff;
    logic [31:0] x;
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = {2'b01, c[4:2]};
    rsp  = {2'b01, c[9:7]};
    imm6 = {{6{c[12]}}, c[12], c[6:2]};
    ill  = 1'b0;
    x    = {16'h0000, c};
    case ({c[1:0], c[15:13]})
      5'b00_000: begin
        off = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
        if (off == 12'd0) ill = 1'b1;
        else x = fmt_i(off, 5'd2, 3'd0, rdp, OPCODE_OPIMM);
      end
      5'b00_010: x = fmt_i({5'b0, c[5], c[12:10], c[6], 2'b00}, rsp, 3'd2, rdp, OPCODE_LOAD);
      5'b00_110: x = fmt_s({5'b0, c[5], c[12:10], c[6], 2'b00}, rdp, rsp);
      5'b01_000: x = fmt_i(imm6, rd, 3'd0, rd, OPCODE_OPIMM);
      5'b01_001, 5'b01_101: begin
        // c.jal links x1 and c.j links x0
        joff = {{10{c[12]}}, c[8], c[10], c[9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        x = {joff[20], joff[10:1], joff[11], joff[19:12], c[15] ? 5'd0 : 5'd1, OPCODE_JAL};
      end
      5'b01_010: x = fmt_i(imm6, 5'd0, 3'd0, rd, OPCODE_OPIMM);
      5'b01_011: begin
        if ({c[12], c[6:2]} == 6'd0) ill = 1'b1;
        else if (rd == 5'd2) begin
          off = {{3{c[12]}}, c[4], c[3], c[5], c[2], c[6], 4'b0000};
          x = fmt_i(off, 5'd2, 3'd0, 5'd2, OPCODE_OPIMM);
        end else x = {{14{c[12]}}, c[12], c[6:2], rd, OPCODE_LUI};
      end
      5'b01_100: begin
        case (c[11:10])
          2'b00: if (c[12]) ill = 1'b1;
                 else x = fmt_i({7'b0, c[6:2]}, rsp, 3'd5, rsp, OPCODE_OPIMM);
          2'b01: if (c[12]) ill = 1'b1;
                 else x = fmt_i({7'b0100000, c[6:2]}, rsp, 3'd5, rsp, OPCODE_OPIMM);
          2'b10: x = fmt_i(imm6, rsp, 3'd7, rsp, OPCODE_OPIMM);
          default: begin
            if (c[12]) ill = 1'b1;
            else if (c[6:5] == 2'b00) x = fmt_r(7'h20, rdp, rsp, 3'd0, rsp);
            else if (c[6:5] == 2'b01) x = fmt_r(7'h00, rdp, rsp, 3'd4, rsp);
            else if (c[6:5] == 2'b10) x = fmt_r(7'h00, rdp, rsp, 3'd6, rsp);
            else x = fmt_r(7'h00, rdp, rsp, 3'd7, rsp);
          end
        endcase
      end
      5'b01_110, 5'b01_111: begin
        boff = {{5{c[12]}}, c[6], c[5], c[2], c[11], c[10], c[4], c[3], 1'b0};
        x = {boff[12], boff[10:5], 5'd0, rsp, 2'b00, c[13], boff[4:1], boff[11],
             OPCODE_BRANCH};
      end
      5'b10_000: if (c[12]) ill = 1'b1;
                 else x = fmt_i({7'b0, c[6:2]}, rd, 3'd1, rd, OPCODE_OPIMM);
      5'b10_010: begin
        if (rd == 5'd0) ill = 1'b1;
        else x = fmt_i({4'b0, c[3:2], c[12], c[6:4], 2'b00}, 5'd2, 3'd2, rd, OPCODE_LOAD);
      end
      5'b10_100: begin
        if (rs2 != 5'd0) x = fmt_r(7'h00, rs2, c[12] ? rd : 5'd0, 3'd0, rd);
        else if (rd != 5'd0) x = fmt_i(12'd0, rd, 3'd0, {4'b0, c[12]}, OPCODE_JALR);
        else if (c[12]) x = EBREAK_INSTR;
        else ill = 1'b1;
      end
      5'b10_110: x = fmt_s({4'b0, c[8:7], c[12:9], 2'b00}, rs2, 5'd2);
      default: ill = 1'b1;   // fp forms
    endcase
    if (ill) x = {16'h0000, c};
    return x;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // monitor and error reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_value(string name, logic [31:0] exp_v, logic [31:0] got_v);
    err_cnt++;
    $display("Fail t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
  endtask

  task automatic report_text(string what);
    err_cnt++;
    $display("Error at t=%0t: %s", $time, what);
  endtask

  always @(posedge clk_i) begin
    if_id_t e;
    if (!space_o) saw_full = 1;
    // outputs must hold while decode stalls
    if (stalled_q) begin
      assert (instr_valid_o && if_id_o == stall_val)
        else report_text("output changed while id_ready_i was low");
    end
    stalled_q = instr_valid_o && !id_ready_i && !jump_i && !rst_i;
    stall_val = if_id_o;
    if (!rst_i && instr_valid_o && id_ready_i) begin
      assert (exp_q.size() != 0)
        else report_text($sformatf("unexpected instruction at pc %h", if_id_o.pc));
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (if_id_o.pc == e.pc) else report_value("pc", e.pc, if_id_o.pc);
        assert (if_id_o.instr == e.instr) else report_value("instr", e.instr, if_id_o.instr);
        assert (if_id_o.is_compressed == e.is_compressed)
          else report_value("is_compressed", 32'(e.is_compressed), 32'(if_id_o.is_compressed));
        assert (if_id_o.illegal == e.illegal)
          else report_value("illegal", 32'(e.illegal), 32'(if_id_o.illegal));
        assert (if_id_o.bus_err == e.bus_err)
          else report_value("bus_err", 32'(e.bus_err), 32'(if_id_o.bus_err));
      end
    end
  end

  // hang guard whose limit grows with every queued instruction
  initial begin
    while ($time <= limit_ns) @(posedge clk_i);
    report_text("timeout while the DUT stopped delivering instructions");
    $display("errors: %0d", err_cnt);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic push_word(logic [31:0] w);
    hw_q.push_back(w[15:0]);
    hw_q.push_back(w[31:16]);
  endtask

  task automatic push_rand_comp(logic [1:0] q, logic [2:0] f3);
    logic [31:0] r;
    logic [15:0] c;
    logic        ill;
    r = $random(seed);
    c = {f3, r[12:2], q};
    void'(ref_expand(c, ill));
    if (!ill) hw_q.push_back(c);
  endtask

  task automatic push_rand_mix(int n);
    logic [31:0] r;
    repeat (n) begin
      r = $random(seed);
      if (r[0]) push_word(r | 32'h3);
      else if (r[2:1] != 2'b11) push_rand_comp(r[2:1], r[5:3]);
      else hw_q.push_back(16'h0001);
    end
  endtask

  task automatic do_jump(logic [31:0] addr);
    @(negedge clk_i);
    jump_i      = 1'b1;
    jump_addr_i = addr;
    @(negedge clk_i);
    jump_i      = 1'b0;
  endtask

  // plays the memory with one word per cycle while space_o allows
  task automatic send_words(bus_resp_t wq[$]);
    int idx;
    idx = 0;
    while (idx < wq.size()) begin
      @(negedge clk_i);
      if (space_o) begin
        resp_valid_i = 1'b1;
        resp_i       = wq[idx];
        idx++;
      end else begin
        resp_valid_i = 1'b0;
      end
    end
    @(negedge clk_i);
    resp_valid_i = 1'b0;
  endtask

  task automatic run_stream(logic [31:0] addr, bit err_en, bit rand_ready);
    logic [15:0] full_q[$];
    bus_resp_t   wq[$];
    bit          werr[$];
    bus_resp_t   w;
    if_id_t      e;
    logic        ill;
    int          i;
    int          hold;
    bit          done;
    logic [31:0] pc;
    done = 0;
    if (addr[1]) full_q.push_back(16'h0001);   // discarded low half
    foreach (hw_q[k]) full_q.push_back(hw_q[k]);
    if (full_q.size() % 2 == 1) full_q.push_back(16'h0001);
    for (int k = 0; k < full_q.size() / 2; k++) begin
      w.rdata = {full_q[2*k+1], full_q[2*k]};
      w.err   = err_en && (($random(seed) & 3) == 0);
      werr.push_back(w.err);
      wq.push_back(w);
    end
    // expected transfers by the pc rule
    i  = addr[1] ? 1 : 0;
    pc = addr;
    while (i < full_q.size()) begin
      e.pc = pc;
      if (full_q[i][1:0] != 2'b11) begin
        e.instr         = ref_expand(full_q[i], ill);
        e.illegal       = ill;
        e.is_compressed = 1'b1;
        e.bus_err       = werr[i/2];
        i  += 1;
        pc += 2;
      end else begin
        e.instr         = {full_q[i+1], full_q[i]};
        e.illegal       = 1'b0;
        e.is_compressed = 1'b0;
        e.bus_err       = werr[i/2] | werr[(i+1)/2];
        i  += 2;
        pc += 4;
      end
      exp_q.push_back(e);
      queued++;
    end
    limit_ns = longint'(queued) * 200 * 8 + 1000;
    hw_q.delete();
    fork
      send_words(wq);
      begin
        while (exp_q.size() != 0) @(posedge clk_i);
        done = 1;
      end
      if (rand_ready) begin
        @(negedge clk_i);
        id_ready_i = 1'b0;
        repeat (16) @(negedge clk_i);
        while (!done) begin
          id_ready_i = ~id_ready_i;
          hold = ($random(seed) & 7) + 1;
          repeat (hold) @(negedge clk_i);
        end
        id_ready_i = 1'b1;
      end
    join
    repeat (4) @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic full_word_stream();
    repeat (12) push_word($random(seed) | 32'h3);
    run_stream(`BOOT_ADDR, 0, 0);
  endtask

  task automatic compressed_form_sweep();
    logic [15:0] forms[12];
    // jr jalr mv add addi16sp and the register alu forms are rare in random fill
    forms = '{16'h8082, 16'h9282, 16'h8426, 16'h952e, 16'h6141, 16'h8005, 16'h848d,
              16'h997d, 16'h8c05, 16'h8c25, 16'h8c45, 16'h8c65};
    hw_q.push_back(16'h9002);   // c.ebreak
    hw_q.push_back(16'h0001);   // c.nop
    hw_q.push_back(16'h4005);   // c.li x0 hint
    hw_q.push_back(16'h0016);   // c.slli x0 hint
    foreach (forms[k]) hw_q.push_back(forms[k]);
    for (int q = 0; q < 3; q++) begin
      for (int f = 0; f < 8; f++) begin
        repeat (8) push_rand_comp(q[1:0], f[2:0]);
      end
    end
    do_jump(32'h0000_0200);
    run_stream(32'h0000_0200, 0, 0);
  endtask

  task automatic straddle_with_errors();
    push_rand_mix(40);
    do_jump(32'h0000_0302);
    run_stream(32'h0000_0302, 1, 0);
  endtask

  task automatic illegal_encodings();
    logic [15:0] bad[15];
    bad = '{16'h0000, 16'h0004, 16'h6181, 16'h6101, 16'h9085, 16'h9485, 16'h9c89,
            16'h9ca9, 16'h1086, 16'h4012, 16'h8002, 16'h2000, 16'ha000, 16'h2002,
            16'h6000};
    foreach (bad[k]) begin
      hw_q.push_back(bad[k]);
      hw_q.push_back(16'h0001);
    end
    do_jump(32'h0000_0100);
    run_stream(32'h0000_0100, 0, 0);
  endtask

  task automatic jump_discards_queue();
    bus_resp_t old_q[$];
    bus_resp_t w;
    // old stream queues up behind a stalled decode
    // one word sits in the output register and the rest fill the FIFO
    @(negedge clk_i);
    id_ready_i = 1'b0;
    for (int k = 0; k < `FIFO_DEPTH + 1; k++) begin
      w.rdata = $random(seed) | 32'h3;
      w.err   = 1'b0;
      old_q.push_back(w);
    end
    send_words(old_q);
    assert (!space_o) else report_text("space_o stayed high with the FIFO full");
    do_jump(32'h0000_0406);
    id_ready_i = 1'b1;
    push_rand_mix(12);
    run_stream(32'h0000_0406, 0, 0);
  endtask

  task automatic random_backpressure();
    saw_full = 0;
    push_rand_mix(40);
    do_jump(32'h0000_0500);
    run_stream(32'h0000_0500, 0, 1);
    assert (saw_full) else report_text("space_o never fell while decode stalled");
  endtask

  initial begin
    rst_i        = 1'b1;
    resp_valid_i = 1'b0;
    resp_i       = '0;
    jump_i       = 1'b0;
    jump_addr_i  = '0;
    id_ready_i   = 1'b1;
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    assert (!instr_valid_o && space_o) else report_text("bad state after reset");
    full_word_stream();
    compressed_form_sweep();
    straddle_with_errors();
    illegal_encodings();
    jump_discards_queue();
    random_backpressure();
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
